// ==== Bender.yml ====
package:
  name: channel_buffer

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/streamPkg.sv
      - design/fifoRam.sv
      - design/fifoController.sv
      - design/channelSplitter.sv
      - design/roundRobinMerger.sv
      - design/channelBuffer.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/channelBuffer_properties.sv
      - tests/channelBuffer_tb.sv

// ==== build.f ====
+incdir+design
design/streamPkg.sv
design/fifoRam.sv
design/fifoController.sv
design/channelSplitter.sv
design/roundRobinMerger.sv
design/channelBuffer.sv
tests/channelBuffer_properties.sv
tests/channelBuffer_tb.sv

// ==== design/channelBuffer.sv ====
`include "stream_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module channelBuffer (
    input  wire logic                   iClk,
    input  wire logic                   rstN,
    // source side
    input  wire logic                   iWe,
    input  wire streamPkg::streamWord_u iWord,
    output logic                        oFull,
    output logic                        oDrop,
    // sink side
    input  wire logic                   iReady,
    output logic                        oValid,
    output logic [`STREAM_WORD_W-2:0]   oData,
    output streamPkg::channelIdx_t      oChannel
);

    // ----------------------------------------
    // internal nets
    // ----------------------------------------
    logic [`CHANNEL_COUNT-1:0]                     wrEn;
    logic [`CHANNEL_COUNT-1:0]                     full;
    logic [`CHANNEL_COUNT-1:0]                     rdEn;
    logic [`CHANNEL_COUNT-1:0]                     rdValid;
    logic [`STREAM_WORD_W-2:0]                     wrData;
    logic [`CHANNEL_COUNT-1:0][`STREAM_WORD_W-2:0] rdData;

    // header decode and write steering
    channelSplitter u_splitter (
        .iClk   (iClk),
        .rstN   (rstN),
        .iWe    (iWe),
        .iWord  (iWord),
        .oFull  (oFull),
        .oDrop  (oDrop),
        .full   (full),
        .wrEn   (wrEn),
        .wrData (wrData)
    );

    // one FIFO per channel, empty level unused here
    generate
        for (genvar i = 0; i < `CHANNEL_COUNT; i++)
        begin : gChannel
            fifoController #(
                .DEPTH        (`FIFO_DEPTH),
                .WIDTH        (`STREAM_WORD_W - 1),
                .almostMargin (`FIFO_ALMOST_MARGIN),
                .useBlockRam  ("yes")
            ) u_fifo (
                .iClk  (iClk),
                .rstN  (rstN),
                .iWe   (wrEn[i]),
                .iWd   (wrData),
                .oFull (full[i]),
                .iRe   (rdEn[i]),
                .oRd   (rdData[i]),
                .oRvd  (rdValid[i]),
                .oEmp  ()
            );
        end
    endgenerate

    // drain all channels onto one tagged stream
    roundRobinMerger u_merger (
        .iClk     (iClk),
        .rstN     (rstN),
        .iReady   (iReady),
        .oValid   (oValid),
        .oData    (oData),
        .oChannel (oChannel),
        .rdEn     (rdEn),
        .rdValid  (rdValid),
        .rdData   (rdData)
    );

endmodule

`default_nettype wire

// ==== design/channelSplitter.sv ====
`include "stream_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module channelSplitter (
    input  wire logic                      iClk,
    input  wire logic                      rstN,
    // source side
    input  wire logic                      iWe,
    input  wire streamPkg::streamWord_u    iWord,
    output logic                           oFull,
    output logic                           oDrop,
    // channel FIFO side
    input  wire logic [`CHANNEL_COUNT-1:0] full,
    output logic      [`CHANNEL_COUNT-1:0] wrEn,
    output logic      [`STREAM_WORD_W-2:0] wrData
);

    // ----------------------------------------
    // word decode
    // ----------------------------------------
    streamPkg::channelIdx_t selChannel;

    logic headerWr;
    logic payloadWr;
    logic selFull;

    // flag bit sits at the same place in both views
    assign headerWr  = iWe && iWord.header.isHeader;
    assign payloadWr = iWe && !iWord.payload.isHeader;

    // full level of the channel in use
    assign selFull = full[selChannel];
    assign oFull   = selFull;

    // payload bits go to every FIFO, only one gets the strobe
    assign wrData = iWord.payload.data;

    // ----------------------------------------
    // channel select
    // ----------------------------------------
    // header takes effect on the next edge
    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
            selChannel <= '0;
        else if (headerWr)
            selChannel <= iWord.header.channel;
    end

    // payload strobe steering, same cycle as the write
    always_comb
    begin
        for (int i = 0; i < `CHANNEL_COUNT; i++)
        begin
            wrEn[i] = payloadWr && (selChannel == streamPkg::channelIdx_t'(i)) && !full[i];
        end
    end

    // ----------------------------------------
    // drop report
    // ----------------------------------------
    // one pulse per payload write lost to a full channel
    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
            oDrop <= 1'b0;
        else
            oDrop <= payloadWr && selFull;
    end

endmodule

`default_nettype wire

// ==== design/fifoController.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifoController #(
    parameter int    DEPTH        = 16,
    parameter int    WIDTH        = 15,
    parameter int    almostMargin = 4,
    parameter string useBlockRam  = "yes"
)(
    input  wire logic             iClk,
    input  wire logic             rstN,
    // write side
    input  wire logic             iWe,
    input  wire logic [WIDTH-1:0] iWd,
    output logic                  oFull,
    // read side
    input  wire logic             iRe,
    output logic      [WIDTH-1:0] oRd,
    output logic                  oRvd,
    output logic                  oEmp
);

    localparam int ADDR_W = $clog2(DEPTH);

    // ----------------------------------------
    // pointers
    // ----------------------------------------
    logic [ADDR_W-1:0] wrPtr;
    logic [ADDR_W-1:0] rdPtr;
    // read pointer one cycle back, a change means new data
    logic [ADDR_W-1:0] prevRdPtr;

    logic emptyNow;
    logic nearFull;
    logic rdAccept;
    logic rdMoved;

    // unregistered empty, gates the read strobe
    assign emptyNow = (wrPtr == rdPtr);
    // strobe while empty is ignored
    assign rdAccept = iRe && !emptyNow;
    assign rdMoved  = (rdPtr != prevRdPtr);

    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
        begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            prevRdPtr <= '0;
        end
        else
        begin
            if (iWe)
                wrPtr <= wrPtr + 1'b1;
            if (rdAccept)
                rdPtr <= rdPtr + 1'b1;
            prevRdPtr <= rdPtr;
        end
    end

    // ----------------------------------------
    // almost-full detect
    // ----------------------------------------
    // read pointer within the next almostMargin write slots
    always_comb
    begin
        nearFull = 1'b0;
        for (int n = 1; n <= almostMargin; n++)
        begin
            if (ADDR_W'(wrPtr + n) == rdPtr)
                nearFull = 1'b1;
        end
    end

    // registered status levels
    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
        begin
            oFull <= 1'b0;
            oEmp  <= 1'b1;
            oRvd  <= 1'b0;
        end
        else
        begin
            oFull <= nearFull;
            oEmp  <= emptyNow;
            oRvd  <= rdMoved;
        end
    end

    // ----------------------------------------
    // storage and output data
    // ----------------------------------------
    logic [WIDTH-1:0] ramData;

    fifoRam #(
        .DEPTH       (DEPTH),
        .WIDTH       (WIDTH),
        .ADDR_W      (ADDR_W),
        .useBlockRam (useBlockRam)
    ) u_ram (
        .iClk   (iClk),
        .wrEn   (iWe),
        .wrAddr (wrPtr),
        .wrData (iWd),
        .rdAddr (rdPtr),
        .rdData (ramData)
    );

    // second cycle of read latency, lines up with oRvd
    always_ff @(posedge iClk)
    begin
        oRd <= ramData;
    end

endmodule

`default_nettype wire

// ==== design/fifoRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifoRam #(
    parameter int    DEPTH       = 16,
    parameter int    WIDTH       = 15,
    parameter int    ADDR_W      = 4,
    parameter string useBlockRam = "yes"
)(
    input  wire logic              iClk,
    input  wire logic              wrEn,
    input  wire logic [ADDR_W-1:0] wrAddr,
    input  wire logic [WIDTH-1:0]  wrData,
    input  wire logic [ADDR_W-1:0] rdAddr,
    output logic      [WIDTH-1:0]  rdData
);

    // ----------------------------------------
    // storage, block RAM or flops
    // ----------------------------------------
    generate
        if (useBlockRam == "yes")
        begin : gBlock
            (* ram_style = "block" *) logic [WIDTH-1:0] mem [DEPTH];

            // write on the edge, read data registered every cycle
            always_ff @(posedge iClk)
            begin
                if (wrEn)
                    mem[wrAddr] <= wrData;
                rdData <= mem[rdAddr];
            end
        end
        else
        begin : gReg
            (* ram_style = "registers" *) logic [WIDTH-1:0] mem [DEPTH];

            // same timing as the block RAM variant
            always_ff @(posedge iClk)
            begin
                if (wrEn)
                    mem[wrAddr] <= wrData;
                rdData <= mem[rdAddr];
            end
        end
    endgenerate

endmodule

`default_nettype wire

// ==== design/roundRobinMerger.sv ====
`include "stream_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module roundRobinMerger (
    input  wire logic                                          iClk,
    input  wire logic                                          rstN,
    // sink side
    input  wire logic                                          iReady,
    output logic                                               oValid,
    output logic                    [`STREAM_WORD_W-2:0]       oData,
    output streamPkg::channelIdx_t                             oChannel,
    // channel FIFO side
    output logic                    [`CHANNEL_COUNT-1:0]       rdEn,
    input  wire logic               [`CHANNEL_COUNT-1:0]       rdValid,
    input  wire logic [`CHANNEL_COUNT-1:0][`STREAM_WORD_W-2:0] rdData
);

    // ----------------------------------------
    // read strobe rotation
    // ----------------------------------------
    streamPkg::channelIdx_t rrPtr;

    // one channel per cycle, 0 1 2 3, held while the sink stalls
    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
            rrPtr <= '0;
        else if (iReady)
        begin
            if (rrPtr == streamPkg::channelIdx_t'(`CHANNEL_COUNT - 1))
                rrPtr <= '0;
            else
                rrPtr <= rrPtr + 1'b1;
        end
    end

    // one-hot strobe, nothing issued without iReady
    always_comb
    begin
        rdEn = '0;
        if (iReady)
            rdEn[rrPtr] = 1'b1;
    end

    // ----------------------------------------
    // valid encode and output register
    // ----------------------------------------
    streamPkg::channelIdx_t hitIdx;

    logic [`STREAM_WORD_W-2:0] hitData;
    logic                      anyValid;

    // strobes never overlap, so at most one valid per cycle
    always_comb
    begin
        hitIdx  = '0;
        hitData = '0;
        for (int i = 0; i < `CHANNEL_COUNT; i++)
        begin
            if (rdValid[i])
            begin
                hitIdx  = streamPkg::channelIdx_t'(i);
                hitData = rdData[i];
            end
        end
    end

    assign anyValid = |rdValid;

    // valid pulse
    always_ff @(posedge iClk or negedge rstN)
    begin
        if (!rstN)
            oValid <= 1'b0;
        else
            oValid <= anyValid;
    end

    // tagged data, only meaningful with oValid
    always_ff @(posedge iClk)
    begin
        if (anyValid)
        begin
            oData    <= hitData;
            oChannel <= hitIdx;
        end
    end

endmodule

`default_nettype wire

// ==== design/streamPkg.sv ====
`include "stream_consts.svh"

`default_nettype none

package streamPkg;

    // channel number, 2 bits for 4 channels
    typedef logic [$clog2(`CHANNEL_COUNT)-1:0] channelIdx_t;

    // one link word, decoded two ways
    // msb is the header flag in both views
    typedef union packed {
        // header view, flag set
        struct packed {
            logic                                       isHeader;
            channelIdx_t                                channel;
            logic [`STREAM_WORD_W-$clog2(`CHANNEL_COUNT)-2:0] reserved;
        } header;
        // payload view, flag clear
        struct packed {
            logic                      isHeader;
            logic [`STREAM_WORD_W-2:0] data;
        } payload;
    } streamWord_u;

endpackage

`default_nettype wire

// ==== design/stream_consts.svh ====
`ifndef STREAM_CONSTS_SVH
`define STREAM_CONSTS_SVH

`default_nettype none

// ----------------------------------------
// stream link sizes
// ----------------------------------------

// one link word, header flag included
`define STREAM_WORD_W 16

// number of channel FIFOs behind the splitter
`define CHANNEL_COUNT 4

// words held per channel FIFO, power of two
`define FIFO_DEPTH 16

// free slots left when the full level rises
`define FIFO_ALMOST_MARGIN 4

`default_nettype wire

`endif

// ==== tests/channelBuffer_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module channelBuffer_properties (
    input wire logic                   iClk,
    input wire logic                   rstN,
    input wire logic                   iWe,
    input wire streamPkg::streamWord_u iWord,
    input wire logic                   iReady,
    input wire logic                   oFull,
    input wire logic                   oDrop,
    input wire logic                   oValid
);

    // read back by the testbench at the end
    int failCount = 0;

    logic payloadWr;

    assign payloadWr = iWe && !iWord.payload.isHeader;

    // ----------------------------------------
    // reset and drop rules
    // ----------------------------------------
    // outputs quiet on the first edge after release
    resetQuiet: assert property (@(posedge iClk) $rose(rstN) |-> !oValid && !oDrop && !oFull)
    else
    begin
        failCount++;
        $error("outputs active right after reset release");
    end

    // payload under full always reported
    dropOnFull: assert property (@(posedge iClk) disable iff (!rstN)
        payloadWr && oFull |=> oDrop)
    else
    begin
        failCount++;
        $error("payload write while full gave no drop pulse");
    end

    // and nothing else is
    dropCause: assert property (@(posedge iClk) disable iff (!rstN)
        oDrop |-> $past(payloadWr && oFull))
    else
    begin
        failCount++;
        $error("drop pulse without a payload write while full");
    end

    // ----------------------------------------
    // sink back-pressure
    // ----------------------------------------
    // two reads in flight plus the output register
    stallLimit: assert property (@(posedge iClk) disable iff (!rstN)
        (!iReady) [*4] |-> !oValid)
    else
    begin
        failCount++;
        $error("valid pulse more than three cycles into a stall");
    end

endmodule

bind channelBuffer channelBuffer_properties u_props (
    .iClk   (iClk),
    .rstN   (rstN),
    .iWe    (iWe),
    .iWord  (iWord),
    .iReady (iReady),
    .oFull  (oFull),
    .oDrop  (oDrop),
    .oValid (oValid)
);

`default_nettype wire

// ==== tests/channelBuffer_tb.sv ====
`include "stream_consts.svh"

`timescale 1ns/1ps
`default_nettype none

module channelBuffer_tb;

    // fill level at which the full level may first show
    localparam int FILL_LIMIT = `FIFO_DEPTH - `FIFO_ALMOST_MARGIN;
    localparam int WAIT_LIMIT = 200;

    logic                      iClk;
    logic                      rstN;
    logic                      iWe;
    streamPkg::streamWord_u    iWord;
    logic                      iReady;
    logic                      oFull;
    logic                      oDrop;
    logic                      oValid;
    logic [`STREAM_WORD_W-2:0] oData;
    streamPkg::channelIdx_t    oChannel;

    // scoreboard, one expected queue per channel
    logic [`STREAM_WORD_W-2:0] expQ [`CHANNEL_COUNT][$];
    int                        held [`CHANNEL_COUNT];
    streamPkg::channelIdx_t    curCh;

    int seed;
    int checkErrors;
    int timeouts;
    int storedCount;
    int outCount;
    int dropExpected;
    int dropSeen;
    // 0 random, 1 held low, 2 held high
    int readyMode;
    int readyRun;

    channelBuffer u_dut (
        .iClk     (iClk),
        .rstN     (rstN),
        .iWe      (iWe),
        .iWord    (iWord),
        .oFull    (oFull),
        .oDrop    (oDrop),
        .iReady   (iReady),
        .oValid   (oValid),
        .oData    (oData),
        .oChannel (oChannel)
    );

    initial
    begin
        iClk = 1'b0;
        forever #20 iClk = ~iClk;
    end

    // ----------------------------------------
    // output monitor, sampled mid-cycle
    // ----------------------------------------
    task automatic checkOutput();
        logic [`STREAM_WORD_W-2:0] expData;
        outCount++;
        assert (expQ[oChannel].size() > 0)
        else
        begin
            checkErrors++;
            $display("unexpected word 0x%04h on channel %0d", oData, oChannel);
        end
        if (expQ[oChannel].size() > 0)
        begin
            expData = expQ[oChannel].pop_front();
            held[oChannel]--;
            assert (oData == expData)
            else
            begin
                checkErrors++;
                $display("[FAIL] oData ch 0x%0h got 0x%04h exp 0x%04h", oChannel, oData, expData);
            end
        end
    endtask

    always @(negedge iClk)
    begin
        if (rstN)
        begin
            // held count overestimates the fill, so this bound is safe
            assert (!oFull || held[curCh] >= FILL_LIMIT)
            else
            begin
                checkErrors++;
                $display("[FAIL] oFull 0x%0h with held 0x%0h on ch 0x%0h", oFull, held[curCh], curCh);
            end
            if (oDrop)
                dropSeen++;
            if (oValid)
                checkOutput();
        end
    end

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------
    // sink level, random runs unless forced
    task automatic updateReady();
        if (readyMode == 1)
            iReady = 1'b0;
        else if (readyMode == 2)
            iReady = 1'b1;
        else
        begin
            if (readyRun == 0)
            begin
                iReady   = ($random(seed) & 3) != 0;
                readyRun = 1 + ($unsigned($random(seed)) % 8);
            end
            readyRun--;
        end
    endtask

    task automatic nextCycle();
        @(posedge iClk);
        #2;
        updateReady();
    endtask

    function automatic int pendingWords();
        int total;
        total = 0;
        for (int i = 0; i < `CHANNEL_COUNT; i++)
            total += expQ[i].size();
        return total;
    endfunction

    // source stalls while full, sink forced on meanwhile
    task automatic waitNotFull();
        int tries;
        tries = 0;
        while (oFull && tries < WAIT_LIMIT)
        begin
            readyMode = 2;
            nextCycle();
            tries++;
        end
        readyMode = 0;
        if (oFull)
        begin
            timeouts++;
            $display("timeout: channel %0d stayed full with the sink ready", curCh);
        end
    endtask

    task automatic writeHeader(input streamPkg::channelIdx_t ch);
        logic [31:0] rnd;
        rnd = $random(seed);
        // reserved bits left random
        iWord                 = rnd[`STREAM_WORD_W-1:0];
        iWord.header.isHeader = 1'b1;
        iWord.header.channel  = ch;
        iWe                   = 1'b1;
        nextCycle();
        iWe   = 1'b0;
        // select takes effect at the edge just passed
        curCh = ch;
    endtask

    task automatic writePayload(input bit honor);
        logic [31:0] rnd;
        logic        accepted;
        if (honor)
            waitNotFull();
        rnd      = $random(seed);
        // a write under oFull is lost
        accepted = !oFull;
        iWord    = {1'b0, rnd[`STREAM_WORD_W-2:0]};
        iWe      = 1'b1;
        if (accepted)
        begin
            expQ[curCh].push_back(iWord.payload.data);
            held[curCh]++;
            storedCount++;
        end
        else
            dropExpected++;
        nextCycle();
        iWe = 1'b0;
    endtask

    task automatic sendPacket();
        logic [31:0] rnd;
        int          count;
        rnd   = $random(seed);
        writeHeader(rnd[1:0]);
        count = 1 + ($unsigned($random(seed)) % 20);
        for (int k = 0; k < count; k++)
            writePayload(1'b1);
    endtask

    task automatic drain();
        int tries;
        tries     = 0;
        readyMode = 2;
        while (pendingWords() > 0 && tries < WAIT_LIMIT)
        begin
            nextCycle();
            tries++;
        end
        if (pendingWords() > 0)
        begin
            timeouts++;
            $display("timeout: %0d words never left the buffer", pendingWords());
        end
        // room for any stray word after the last one
        repeat (8) nextCycle();
    endtask

    task automatic closeRun();
        int assertFails;
        assertFails = u_dut.u_props.failCount;
        $display("errors: checks %0d, assertions %0d, timeouts %0d",
                 checkErrors, assertFails, timeouts);
        if (checkErrors == 0 && assertFails == 0 && timeouts == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial
    begin
        seed         = 32'h6004_7277;
        rstN         = 1'b0;
        iWe          = 1'b0;
        iWord        = '0;
        iReady       = 1'b0;
        curCh        = '0;
        checkErrors  = 0;
        timeouts     = 0;
        storedCount  = 0;
        outCount     = 0;
        dropExpected = 0;
        dropSeen     = 0;
        readyMode    = 0;
        readyRun     = 0;
        for (int i = 0; i < `CHANNEL_COUNT; i++)
            held[i] = 0;

        repeat (10) @(posedge iClk);
        #2;
        rstN = 1'b1;
        nextCycle();

        // random packets, full level honored
        for (int p = 0; p < 60; p++)
            sendPacket();

        // overflow, sink stalled, writes ignore oFull
        readyMode = 1;
        repeat (4) nextCycle();
        writeHeader(2'd2);
        for (int k = 0; k < `FIFO_DEPTH; k++)
            writePayload(1'b0);

        drain();

        // end of run totals
        for (int i = 0; i < `CHANNEL_COUNT; i++)
        begin
            assert (expQ[i].size() == 0)
            else
            begin
                checkErrors++;
                $display("[FAIL] expQ ch 0x%0h size 0x%0h exp 0x0", i, expQ[i].size());
            end
        end
        assert (outCount == storedCount)
        else
        begin
            checkErrors++;
            $display("[FAIL] oValid count got 0x%0h exp 0x%0h", outCount, storedCount);
        end
        assert (dropSeen == dropExpected)
        else
        begin
            checkErrors++;
            $display("[FAIL] oDrop count got 0x%0h exp 0x%0h", dropSeen, dropExpected);
        end
        assert (dropExpected > 0)
        else
        begin
            checkErrors++;
            $display("overflow phase made no write while full");
        end

        closeRun();
    end

endmodule

`default_nettype wire
